// File: procPkg.sv
// Widths, opcodes, ALU operations, branch kinds and immediate sign extension helpers
package procPkg;

  parameter int WORD_W = 16;
  parameter int REG_ADDR_W = 3;

  // Opcode field in instruction bits 15 to 12
  localparam logic [3:0] OP_HALT = 4'h0;
  localparam logic [3:0] OP_ADD  = 4'h1;
  localparam logic [3:0] OP_SUB  = 4'h2;
  localparam logic [3:0] OP_AND  = 4'h3;
  localparam logic [3:0] OP_XOR  = 4'h4;
  localparam logic [3:0] OP_ADDI = 4'h5;
  localparam logic [3:0] OP_LD   = 4'h6;
  localparam logic [3:0] OP_ST   = 4'h7;
  localparam logic [3:0] OP_BEQZ = 4'h8;
  localparam logic [3:0] OP_BNEZ = 4'h9;
  localparam logic [3:0] OP_J    = 4'hA;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_PASS
  } aluOpT;

  // Control transfer kind carried from decode to execute
  localparam logic [1:0] BR_NONE = 2'd0;
  localparam logic [1:0] BR_EQZ  = 2'd1;
  localparam logic [1:0] BR_NEZ  = 2'd2;
  localparam logic [1:0] BR_J    = 2'd3;

  function automatic logic [WORD_W-1:0] sext6(input logic [5:0] v);
    return {{(WORD_W-6){v[5]}}, v};
  endfunction

  function automatic logic [WORD_W-1:0] sext9(input logic [8:0] v);
    return {{(WORD_W-9){v[8]}}, v};
  endfunction

  function automatic logic [WORD_W-1:0] sext12(input logic [11:0] v);
    return {{(WORD_W-12){v[11]}}, v};
  endfunction

endpackage

// File: fetchStage.sv
// Program counter, fetch request to the arbiter and the IF/ID register of the fetch stage
`timescale 1ns/100ps
module fetchStage
  import procPkg::*;
#(
  parameter int MEM_ADDR_W = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  redirect,
  input  logic [WORD_W-1:0]     redirectPc,
  input  logic                  haltSeen,
  input  logic                  fetchGrant,
  input  logic [WORD_W-1:0]     fetchData,
  output logic                  fetchReq,
  output logic [MEM_ADDR_W-1:0] fetchAddr,
  output logic [WORD_W-1:0]     ifInstr,
  output logic [WORD_W-1:0]     ifPc,
  output logic                  ifValid
);

  logic [WORD_W-1:0] pc;
  logic [WORD_W-1:0] pcNext;
  logic              running;
  logic              fetchOk;

  // No requests until the first cycle out of reset
  assign fetchReq  = running & ~stall & ~haltSeen;
  assign fetchAddr = pc[MEM_ADDR_W-1:0];
  assign pcNext    = pc + 1'b1;
  assign fetchOk   = fetchReq & fetchGrant & ~redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= '0;
      running <= 1'b0;
      ifValid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (redirect) begin
        pc      <= redirectPc;
        ifValid <= 1'b0;
      end else if (!stall) begin
        // Lost arbitration leaves a bubble and keeps the PC
        ifValid <= fetchOk;
        if (fetchOk) pc <= pcNext;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetchOk) begin
      ifInstr <= fetchData;
      ifPc    <= pcNext;
    end
  end

endmodule

// File: decodeStage.sv
// Instruction decode, register file, hazard stall, illegal opcode flag and the ID/EX register
`timescale 1ns/100ps
module decodeStage
  import procPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  memStall,
  input  logic                  redirect,
  input  logic [WORD_W-1:0]     ifInstr,
  input  logic [WORD_W-1:0]     ifPc,
  input  logic                  ifValid,
  input  logic [REG_ADDR_W-1:0] exDestReg,
  input  logic                  exRegWrite,
  input  logic [REG_ADDR_W-1:0] memDestReg,
  input  logic                  memRegWrite,
  input  logic                  wbEn,
  input  logic [REG_ADDR_W-1:0] wbReg,
  input  logic [WORD_W-1:0]     wbData,
  output logic                  hazardStall,
  output logic                  haltSeen,
  output logic                  err,
  output logic                  idValid,
  output aluOpT                 idAluOp,
  output logic [WORD_W-1:0]     idOpA,
  output logic [WORD_W-1:0]     idOpB,
  output logic [WORD_W-1:0]     idStoreData,
  output logic [WORD_W-1:0]     idImm,
  output logic [WORD_W-1:0]     idPc,
  output logic [REG_ADDR_W-1:0] idDest,
  output logic                  idRegWrite,
  output logic                  idMemRead,
  output logic                  idMemWrite,
  output logic [1:0]            idBranchKind,
  output logic                  idHalt
);

  logic [WORD_W-1:0]     regFile [0:(1<<REG_ADDR_W)-1];
  logic [REG_ADDR_W-1:0] srcA, srcB, dest;
  logic [WORD_W-1:0]     valA, valB, imm;
  logic                  useA, useB, useImm, writesReg;
  logic                  isLoad, isStore, isHalt, illegal;
  logic                  hitA, hitB, issue, haltLatched;
  logic [1:0]            branchKind;
  aluOpT                 aluOp;

  always_comb begin
    dest = ifInstr[11:9];
    srcA = ifInstr[8:6];
    srcB = ifInstr[5:3];
    imm = sext6(ifInstr[5:0]);
    {useA, useB, useImm, writesReg} = 4'b0000;
    {isLoad, isStore, isHalt, illegal} = 4'b0000;
    aluOp = ALU_PASS;
    branchKind = BR_NONE;
    case (ifInstr[15:12])
      OP_ADD:  {aluOp, useA, useB, writesReg} = {ALU_ADD, 3'b111};
      OP_SUB:  {aluOp, useA, useB, writesReg} = {ALU_SUB, 3'b111};
      OP_AND:  {aluOp, useA, useB, writesReg} = {ALU_AND, 3'b111};
      OP_XOR:  {aluOp, useA, useB, writesReg} = {ALU_XOR, 3'b111};
      OP_ADDI: {aluOp, useA, useImm, writesReg} = {ALU_ADD, 3'b111};
      OP_LD:   {aluOp, useA, useImm, writesReg, isLoad} = {ALU_ADD, 4'b1111};
      OP_ST: begin
        // Store data register shares the rd field
        srcB = ifInstr[11:9];
        {aluOp, useA, useB, useImm, isStore} = {ALU_ADD, 4'b1111};
      end
      OP_BEQZ, OP_BNEZ: begin
        srcA = ifInstr[11:9];
        useA = 1'b1;
        imm = sext9(ifInstr[8:0]);
        branchKind = (ifInstr[15:12] == OP_BEQZ) ? BR_EQZ : BR_NEZ;
      end
      OP_J: begin
        imm = sext12(ifInstr[11:0]);
        branchKind = BR_J;
      end
      OP_HALT: isHalt = 1'b1;
      default: illegal = 1'b1;
    endcase
  end

  // Register read with writeback bypass and r0 forced to zero
  always_comb begin
    valA = (wbEn && wbReg == srcA) ? wbData : regFile[srcA];
    valB = (wbEn && wbReg == srcB) ? wbData : regFile[srcB];
    if (srcA == '0) valA = '0;
    if (srcB == '0) valB = '0;
  end

  // RAW check against execute and memory stages
  assign hitA = (exRegWrite && exDestReg == srcA) || (memRegWrite && memDestReg == srcA);
  assign hitB = (exRegWrite && exDestReg == srcB) || (memRegWrite && memDestReg == srcB);
  assign hazardStall = ifValid & ((useA & hitA) | (useB & hitB));
  assign issue = ifValid & ~illegal & ~redirect & ~hazardStall;
  assign haltSeen = haltLatched | (ifValid & isHalt);

  always_ff @(posedge clk) begin
    if (reset) begin
      idValid      <= 1'b0;
      idRegWrite   <= 1'b0;
      idMemRead    <= 1'b0;
      idMemWrite   <= 1'b0;
      idBranchKind <= BR_NONE;
      idHalt       <= 1'b0;
      haltLatched  <= 1'b0;
      err          <= 1'b0;
    end else begin
      if (!memStall) begin
        idValid      <= issue;
        idRegWrite   <= issue & writesReg & (dest != '0);
        idMemRead    <= issue & isLoad;
        idMemWrite   <= issue & isStore;
        idBranchKind <= issue ? branchKind : BR_NONE;
        idHalt       <= issue & isHalt;
        if (issue && isHalt) haltLatched <= 1'b1;
      end
      if (ifValid && illegal && !redirect) err <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!memStall) begin
      idAluOp     <= aluOp;
      idOpA       <= valA;
      idOpB       <= useImm ? imm : valB;
      idStoreData <= valB;
      idImm       <= imm;
      idPc        <= ifPc;
      idDest      <= dest;
    end
  end

  always_ff @(posedge clk) begin
    if (wbEn) regFile[wbReg] <= wbData;
  end

  // Writes to r0 are dropped before they reach writeback
  assert property (@(posedge clk) disable iff (reset) wbEn |-> wbReg != '0);

endmodule

// File: executeStage.sv
// ALU, branch and jump resolution, redirect and the EX/MEM register
`timescale 1ns/100ps
module executeStage
  import procPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  memStall,
  input  logic                  idValid,
  input  aluOpT                 idAluOp,
  input  logic [WORD_W-1:0]     idOpA,
  input  logic [WORD_W-1:0]     idOpB,
  input  logic [WORD_W-1:0]     idStoreData,
  input  logic [WORD_W-1:0]     idImm,
  input  logic [WORD_W-1:0]     idPc,
  input  logic [REG_ADDR_W-1:0] idDest,
  input  logic                  idRegWrite,
  input  logic                  idMemRead,
  input  logic                  idMemWrite,
  input  logic [1:0]            idBranchKind,
  input  logic                  idHalt,
  output logic                  redirect,
  output logic [WORD_W-1:0]     redirectPc,
  output logic [REG_ADDR_W-1:0] exDestReg,
  output logic                  exRegWrite,
  output logic                  exValid,
  output logic [WORD_W-1:0]     exResult,
  output logic [WORD_W-1:0]     exStoreData,
  output logic [REG_ADDR_W-1:0] exMemDest,
  output logic                  exMemRegWrite,
  output logic                  exMemRead,
  output logic                  exMemWrite,
  output logic                  exHalt
);

  logic [WORD_W-1:0] aluOut;
  logic              taken;

  always_comb begin
    case (idAluOp)
      ALU_ADD: aluOut = idOpA + idOpB;
      ALU_SUB: aluOut = idOpA - idOpB;
      ALU_AND: aluOut = idOpA & idOpB;
      ALU_XOR: aluOut = idOpA ^ idOpB;
      default: aluOut = idOpA;
    endcase
    case (idBranchKind)
      BR_EQZ:  taken = (idOpA == '0);
      BR_NEZ:  taken = (idOpA != '0);
      BR_J:    taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // Target relative to PC+1 held in idPc
  assign redirect   = taken;
  assign redirectPc = idPc + idImm;

  // Instruction now in execute for the decode hazard check
  assign exDestReg  = idDest;
  assign exRegWrite = idValid & idRegWrite;

  always_ff @(posedge clk) begin
    if (reset) begin
      exValid       <= 1'b0;
      exMemRegWrite <= 1'b0;
      exMemRead     <= 1'b0;
      exMemWrite    <= 1'b0;
      exHalt        <= 1'b0;
    end else if (!memStall) begin
      exValid       <= idValid;
      exMemRegWrite <= exRegWrite;
      exMemRead     <= idValid & idMemRead;
      exMemWrite    <= idValid & idMemWrite;
      exHalt        <= idValid & idHalt;
    end
  end

  always_ff @(posedge clk) begin
    if (!memStall) begin
      exResult    <= aluOut;
      exStoreData <= idStoreData;
      exMemDest   <= idDest;
    end
  end

  // Decode clears the branch kind of every bubble
  assert property (@(posedge clk) disable iff (reset) redirect |-> idValid);

  // Decode must put a bubble behind a taken branch
  assert property (@(posedge clk) disable iff (reset) redirect && !memStall |=> !idValid);

endmodule

// File: memStage.sv
// Data request to the arbiter, stall on denial, MEM/WB register and writeback select
`timescale 1ns/100ps
module memStage
  import procPkg::*;
#(
  parameter int MEM_ADDR_W = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  exValid,
  input  logic [WORD_W-1:0]     exResult,
  input  logic [WORD_W-1:0]     exStoreData,
  input  logic [REG_ADDR_W-1:0] exMemDest,
  input  logic                  exMemRegWrite,
  input  logic                  exMemRead,
  input  logic                  exMemWrite,
  input  logic                  exHalt,
  input  logic                  dataGrant,
  input  logic [WORD_W-1:0]     dataRData,
  output logic                  dataReq,
  output logic                  dataWe,
  output logic [MEM_ADDR_W-1:0] dataAddr,
  output logic [WORD_W-1:0]     dataWData,
  output logic                  memStall,
  output logic [REG_ADDR_W-1:0] memDestReg,
  output logic                  memRegWrite,
  output logic                  wbEn,
  output logic [REG_ADDR_W-1:0] wbReg,
  output logic [WORD_W-1:0]     wbData,
  output logic                  wbHalt
);

  assign dataReq   = exValid & (exMemRead | exMemWrite);
  assign dataWe    = exMemWrite;
  assign dataAddr  = exResult[MEM_ADDR_W-1:0];
  assign dataWData = exStoreData;

  // Denied access freezes the whole pipeline
  assign memStall = dataReq & ~dataGrant;

  assign memDestReg  = exMemDest;
  assign memRegWrite = exValid & exMemRegWrite;

  always_ff @(posedge clk) begin
    if (reset) begin
      wbEn   <= 1'b0;
      wbHalt <= 1'b0;
    end else if (!memStall) begin
      wbEn   <= memRegWrite;
      wbHalt <= exValid & exHalt;
    end
  end

  always_ff @(posedge clk) begin
    if (!memStall) begin
      wbReg  <= exMemDest;
      wbData <= exMemRead ? dataRData : exResult;
    end
  end

endmodule

// File: unifiedMemory.sv
// Fixed-priority arbiter over debug, data and fetch ports and the word array
`timescale 1ns/100ps
module unifiedMemory
  import procPkg::*;
#(
  parameter int MEM_ADDR_W = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  dbgReq,
  input  logic                  dbgWe,
  input  logic [MEM_ADDR_W-1:0] dbgAddr,
  input  logic [WORD_W-1:0]     dbgWData,
  input  logic                  dataReq,
  input  logic                  dataWe,
  input  logic [MEM_ADDR_W-1:0] dataAddr,
  input  logic [WORD_W-1:0]     dataWData,
  input  logic                  fetchReq,
  input  logic [MEM_ADDR_W-1:0] fetchAddr,
  output logic [WORD_W-1:0]     dbgRData,
  output logic                  dataGrant,
  output logic [WORD_W-1:0]     dataRData,
  output logic                  fetchGrant,
  output logic [WORD_W-1:0]     fetchData
);

  logic [WORD_W-1:0] mem [0:(1<<MEM_ADDR_W)-1];
  logic              dbgGrant;

  // Debug first, then data, then fetch
  assign dbgGrant   = dbgReq;
  assign dataGrant  = dataReq & ~dbgReq;
  assign fetchGrant = fetchReq & ~dbgReq & ~dataReq;

  // Only the granted port may write
  always_ff @(posedge clk) begin
    if (dbgGrant && dbgWe) begin
      mem[dbgAddr] <= dbgWData;
    end else if (dataGrant && dataWe) begin
      mem[dataAddr] <= dataWData;
    end
  end

  // Combinational reads valid in the request cycle
  assign dbgRData  = mem[dbgAddr];
  assign dataRData = mem[dataAddr];
  assign fetchData = mem[fetchAddr];

  assert property (@(posedge clk) disable iff (reset)
    $onehot0({dbgGrant, dataGrant, fetchGrant}));

endmodule

// File: proc.sv
// Processor top with stage instances, unified memory, fetch stall and halt register
`timescale 1ns/100ps
module proc
  import procPkg::*;
#(
  parameter int MEM_ADDR_W = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  dbgReq,
  input  logic                  dbgWe,
  input  logic [MEM_ADDR_W-1:0] dbgAddr,
  input  logic [WORD_W-1:0]     dbgWData,
  output logic [WORD_W-1:0]     dbgRData,
  output logic                  halted,
  output logic                  err
);

  logic                  fetchReq, fetchGrant, dataReq, dataWe, dataGrant;
  logic [MEM_ADDR_W-1:0] fetchAddr, dataAddr;
  logic [WORD_W-1:0]     fetchData, dataWData, dataRData;
  logic                  hazardStall, memStall, haltSeen, redirect;
  logic [WORD_W-1:0]     redirectPc, ifInstr, ifPc;
  logic                  ifValid;
  logic                  idValid, idRegWrite, idMemRead, idMemWrite, idHalt;
  aluOpT                 idAluOp;
  logic [WORD_W-1:0]     idOpA, idOpB, idStoreData, idImm, idPc;
  logic [REG_ADDR_W-1:0] idDest, exDestReg, exMemDest, memDestReg, wbReg;
  logic [1:0]            idBranchKind;
  logic                  exRegWrite, exValid, exMemRegWrite, exMemRead, exMemWrite, exHalt;
  logic [WORD_W-1:0]     exResult, exStoreData, wbData;
  logic                  memRegWrite, wbEn, wbHalt;

  fetchStage #(.MEM_ADDR_W(MEM_ADDR_W)) fetch0 (
    .clk, .reset, .stall(hazardStall | memStall), .redirect, .redirectPc, .haltSeen,
    .fetchGrant, .fetchData, .fetchReq, .fetchAddr, .ifInstr, .ifPc, .ifValid
  );

  decodeStage decode0 (
    .clk, .reset, .memStall, .redirect, .ifInstr, .ifPc, .ifValid, .exDestReg,
    .exRegWrite, .memDestReg, .memRegWrite, .wbEn, .wbReg, .wbData, .hazardStall,
    .haltSeen, .err, .idValid, .idAluOp, .idOpA, .idOpB, .idStoreData, .idImm, .idPc,
    .idDest, .idRegWrite, .idMemRead, .idMemWrite, .idBranchKind, .idHalt
  );

  executeStage execute0 (
    .clk, .reset, .memStall, .idValid, .idAluOp, .idOpA, .idOpB, .idStoreData, .idImm,
    .idPc, .idDest, .idRegWrite, .idMemRead, .idMemWrite, .idBranchKind, .idHalt,
    .redirect, .redirectPc, .exDestReg, .exRegWrite, .exValid, .exResult, .exStoreData,
    .exMemDest, .exMemRegWrite, .exMemRead, .exMemWrite, .exHalt
  );

  memStage #(.MEM_ADDR_W(MEM_ADDR_W)) mem0 (
    .clk, .reset, .exValid, .exResult, .exStoreData, .exMemDest, .exMemRegWrite,
    .exMemRead, .exMemWrite, .exHalt, .dataGrant, .dataRData, .dataReq, .dataWe,
    .dataAddr, .dataWData, .memStall, .memDestReg, .memRegWrite, .wbEn, .wbReg,
    .wbData, .wbHalt
  );

  unifiedMemory #(.MEM_ADDR_W(MEM_ADDR_W)) memory0 (
    .clk, .reset, .dbgReq, .dbgWe, .dbgAddr, .dbgWData, .dataReq, .dataWe, .dataAddr,
    .dataWData, .fetchReq, .fetchAddr, .dbgRData, .dataGrant, .dataRData, .fetchGrant,
    .fetchData
  );

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (wbHalt) begin
      halted <= 1'b1;
    end
  end

endmodule

// File: procTb.sv
// Testbench with case table, program builder, debug loads, halt wait and checks
`timescale 1ns/100ps
module procTb;

  localparam int MEM_ADDR_W = 8;
  localparam int HALT_TIMEOUT = 300;

  // Instruction encoding of bits 15 to 12
  localparam logic [3:0] OP_HALT = 4'h0;
  localparam logic [3:0] OP_ADD  = 4'h1;
  localparam logic [3:0] OP_SUB  = 4'h2;
  localparam logic [3:0] OP_AND  = 4'h3;
  localparam logic [3:0] OP_XOR  = 4'h4;
  localparam logic [3:0] OP_ADDI = 4'h5;
  localparam logic [3:0] OP_LD   = 4'h6;
  localparam logic [3:0] OP_ST   = 4'h7;
  localparam logic [3:0] OP_BEQZ = 4'h8;
  localparam logic [3:0] OP_BNEZ = 4'h9;
  localparam logic [3:0] OP_J    = 4'hA;
  localparam logic [3:0] OP_BAD  = 4'hF;

  // Program kinds
  localparam logic [3:0] K_ADD     = 4'd0;
  localparam logic [3:0] K_SUB     = 4'd1;
  localparam logic [3:0] K_AND     = 4'd2;
  localparam logic [3:0] K_XOR     = 4'd3;
  localparam logic [3:0] K_ADDI    = 4'd4;
  localparam logic [3:0] K_LOADUSE = 4'd5;
  localparam logic [3:0] K_BEQZ    = 4'd6;
  localparam logic [3:0] K_BNEZ    = 4'd7;
  localparam logic [3:0] K_JUMP    = 4'd8;
  localparam logic [3:0] K_ILLEGAL = 4'd9;

  // Data words at the top of memory reached by negative offsets from r0
  localparam logic [MEM_ADDR_W-1:0] ADDR_A = 8'hF0;
  localparam logic [MEM_ADDR_W-1:0] ADDR_B = 8'hF1;
  localparam logic [MEM_ADDR_W-1:0] ADDR_T = 8'hF4;
  localparam logic [MEM_ADDR_W-1:0] ADDR_R = 8'hF8;

  typedef struct packed {
    logic [3:0]  kind;
    logic [15:0] a;
    logic [15:0] b;
    logic        randA;
    logic        randB;
    logic        expErr;
  } caseT;

  logic                  clk;
  logic                  reset;
  logic                  dbgReq;
  logic                  dbgWe;
  logic [MEM_ADDR_W-1:0] dbgAddr;
  logic [15:0]           dbgWData;
  logic [15:0]           dbgRData;
  logic                  halted;
  logic                  err;

  caseT        cases [$];
  logic [15:0] prog [$];
  integer      seed;

  proc #(.MEM_ADDR_W(MEM_ADDR_W)) DUT (
    .clk, .reset, .dbgReq, .dbgWe, .dbgAddr, .dbgWData, .dbgRData, .halted, .err
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [15:0] rType(input logic [3:0] op, input logic [2:0] rd, rs, rt);
    return {op, rd, rs, rt, 3'b000};
  endfunction

  function automatic logic [15:0] iType(input logic [3:0] op, input logic [2:0] rd, rs,
                                        input logic [5:0] imm);
    return {op, rd, rs, imm};
  endfunction

  function automatic logic [15:0] brType(input logic [3:0] op, input logic [2:0] rs,
                                         input logic [8:0] off);
    return {op, rs, off};
  endfunction

  // Result each program stores by the ISA rules
  function automatic logic [15:0] expectedResult(input logic [3:0] kind, input logic [15:0] a, b);
    case (kind)
      K_ADD:     return a + b;
      K_SUB:     return a - b;
      K_AND:     return a & b;
      K_XOR:     return a ^ b;
      K_ADDI:    return a + 16'd5 - 16'd3 + 16'd31;
      K_LOADUSE: return a + a + 16'd7;
      K_BEQZ:    return (a == 16'd0) ? 16'd1 : 16'd6;
      K_BNEZ:    return (a != 16'd0) ? 16'd1 : 16'd6;
      K_JUMP:    return a;
      K_ILLEGAL: return a + 16'd1;
      default:   return 16'd0;
    endcase
  endfunction

  task automatic buildProgram(input logic [3:0] kind);
    logic [3:0] aluOp;
    prog.delete();
    case (kind)
      K_ADD, K_SUB, K_AND, K_XOR: begin
        aluOp = (kind == K_ADD) ? OP_ADD : (kind == K_SUB) ? OP_SUB :
                (kind == K_AND) ? OP_AND : OP_XOR;
        prog.push_back(iType(OP_LD, 3'd1, 3'd0, ADDR_A[5:0]));
        prog.push_back(iType(OP_LD, 3'd2, 3'd0, ADDR_B[5:0]));
        // Result consumed by the very next store
        prog.push_back(rType(aluOp, 3'd3, 3'd1, 3'd2));
        prog.push_back(iType(OP_ST, 3'd3, 3'd0, ADDR_R[5:0]));
      end
      K_ADDI: begin
        prog.push_back(iType(OP_LD, 3'd1, 3'd0, ADDR_A[5:0]));
        prog.push_back(iType(OP_ADDI, 3'd2, 3'd1, 6'd5));
        prog.push_back(iType(OP_ADDI, 3'd3, 3'd2, 6'h3D));
        prog.push_back(iType(OP_ADDI, 3'd4, 3'd3, 6'd31));
        prog.push_back(iType(OP_ST, 3'd4, 3'd0, ADDR_R[5:0]));
      end
      K_LOADUSE: begin
        prog.push_back(iType(OP_LD, 3'd1, 3'd0, ADDR_A[5:0]));
        prog.push_back(rType(OP_ADD, 3'd2, 3'd1, 3'd1));
        prog.push_back(iType(OP_ST, 3'd2, 3'd0, ADDR_T[5:0]));
        prog.push_back(iType(OP_LD, 3'd5, 3'd0, ADDR_T[5:0]));
        prog.push_back(iType(OP_ADDI, 3'd5, 3'd5, 6'd7));
        prog.push_back(iType(OP_ST, 3'd5, 3'd0, ADDR_R[5:0]));
      end
      K_BEQZ, K_BNEZ: begin
        prog.push_back(iType(OP_LD, 3'd1, 3'd0, ADDR_A[5:0]));
        prog.push_back(iType(OP_ADDI, 3'd2, 3'd0, 6'd1));
        // Taken skips both corrupting ADDIs
        prog.push_back(brType((kind == K_BEQZ) ? OP_BEQZ : OP_BNEZ, 3'd1, 9'd2));
        prog.push_back(iType(OP_ADDI, 3'd2, 3'd0, 6'd2));
        prog.push_back(iType(OP_ADDI, 3'd2, 3'd2, 6'd4));
        prog.push_back(iType(OP_ST, 3'd2, 3'd0, ADDR_R[5:0]));
      end
      K_JUMP: begin
        prog.push_back(iType(OP_LD, 3'd1, 3'd0, ADDR_A[5:0]));
        prog.push_back({OP_J, 12'd2});
        prog.push_back(iType(OP_ADDI, 3'd1, 3'd1, 6'd2));
        prog.push_back(iType(OP_ADDI, 3'd1, 3'd1, 6'd4));
        prog.push_back(iType(OP_ST, 3'd1, 3'd0, ADDR_R[5:0]));
      end
      default: begin
        prog.push_back(iType(OP_LD, 3'd1, 3'd0, ADDR_A[5:0]));
        prog.push_back(iType(OP_ADDI, 3'd1, 3'd1, 6'd1));
        prog.push_back({OP_BAD, 12'h000});
        prog.push_back(iType(OP_ST, 3'd1, 3'd0, ADDR_R[5:0]));
      end
    endcase
    prog.push_back({OP_HALT, 12'h000});
  endtask

  task automatic checkValue(input logic [15:0] got, expected, input string what);
    if (got !== expected) begin
      $display("[ERROR] t=%0t: %s is %h, expected %h", $time, what, got, expected);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic writeWord(input logic [MEM_ADDR_W-1:0] addr, input logic [15:0] data);
    @(negedge clk);
    dbgReq   = 1'b1;
    dbgWe    = 1'b1;
    dbgAddr  = addr;
    dbgWData = data;
    @(posedge clk);
  endtask

  task automatic readWord(input logic [MEM_ADDR_W-1:0] addr, output logic [15:0] data);
    @(negedge clk);
    dbgReq  = 1'b1;
    dbgWe   = 1'b0;
    dbgAddr = addr;
    @(posedge clk);
    data = dbgRData;
  endtask

  task automatic waitForHalt(input int idx);
    int cycles;
    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("Case %0d: the core did not halt within %0d cycles", idx, HALT_TIMEOUT);
      $display("TEST FAIL");
      $fatal(1, "timeout waiting for halted");
    end
  endtask

  task automatic addCase(input logic [3:0] kind, input logic [15:0] a, b,
                         input logic randA, randB, expErr);
    cases.push_back('{kind, a, b, randA, randB, expErr});
  endtask

  task automatic runCase(input int idx, input logic [3:0] kind, input logic [15:0] a, b,
                         input logic expErr);
    logic [15:0] got;
    logic [15:0] expected;
    int          i;
    expected = expectedResult(kind, a, b);
    @(negedge clk);
    reset = 1'b1;
    buildProgram(kind);
    for (i = 0; i < prog.size(); i++) begin
      writeWord(MEM_ADDR_W'(i), prog[i]);
    end
    writeWord(ADDR_A, a);
    writeWord(ADDR_B, b);
    // Result word starts out different from the expected value
    writeWord(ADDR_R, ~expected);
    for (i = 0; i < prog.size(); i++) begin
      readWord(MEM_ADDR_W'(i), got);
      checkValue(got, prog[i], $sformatf("case %0d program word %0d", idx, i));
    end
    readWord(ADDR_A, got);
    checkValue(got, a, $sformatf("case %0d operand a readback", idx));
    readWord(ADDR_B, got);
    checkValue(got, b, $sformatf("case %0d operand b readback", idx));
    readWord(ADDR_R, got);
    checkValue(got, ~expected, $sformatf("case %0d result word readback", idx));
    @(negedge clk);
    checkValue(16'(halted), 16'd0, $sformatf("case %0d halted before run", idx));
    checkValue(16'(err), 16'd0, $sformatf("case %0d err before run", idx));
    dbgReq = 1'b0;
    dbgWe  = 1'b0;
    reset  = 1'b0;
    waitForHalt(idx);
    checkValue(16'(err), 16'(expErr), $sformatf("case %0d err at halt", idx));
    readWord(ADDR_R, got);
    checkValue(got, expected, $sformatf("case %0d kind %0d result", idx, kind));
    @(negedge clk);
    dbgReq = 1'b0;
  endtask

  initial begin
    caseT        tc;
    logic [15:0] a;
    logic [15:0] b;
    integer      rnd;
    int          idx;
    reset    = 1'b1;
    dbgReq   = 1'b0;
    dbgWe    = 1'b0;
    dbgAddr  = '0;
    dbgWData = '0;
    seed     = 32'h004e1ace;
    repeat (4) @(negedge clk);

    // kind, a, b, random a, random b, expected err
    addCase(K_ADD,     16'h1234, 16'h4321, 1'b0, 1'b0, 1'b0);
    addCase(K_ADD,     16'hFFFF, 16'h0002, 1'b0, 1'b0, 1'b0);
    addCase(K_ADD,     16'h0000, 16'h0000, 1'b1, 1'b1, 1'b0);
    addCase(K_SUB,     16'h0005, 16'h0009, 1'b0, 1'b0, 1'b0);
    addCase(K_SUB,     16'h0000, 16'h0000, 1'b1, 1'b1, 1'b0);
    addCase(K_AND,     16'hF0F0, 16'h3C3C, 1'b0, 1'b0, 1'b0);
    addCase(K_AND,     16'h0000, 16'h0000, 1'b1, 1'b1, 1'b0);
    addCase(K_XOR,     16'hAAAA, 16'h5555, 1'b0, 1'b0, 1'b0);
    addCase(K_XOR,     16'h0000, 16'h0000, 1'b1, 1'b1, 1'b0);
    addCase(K_ADDI,    16'hFFF0, 16'h0000, 1'b0, 1'b0, 1'b0);
    addCase(K_ADDI,    16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0);
    addCase(K_LOADUSE, 16'h7FFF, 16'h0000, 1'b0, 1'b0, 1'b0);
    addCase(K_LOADUSE, 16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0);
    addCase(K_BEQZ,    16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0);
    addCase(K_BEQZ,    16'h0042, 16'h0000, 1'b0, 1'b0, 1'b0);
    addCase(K_BNEZ,    16'h8000, 16'h0000, 1'b0, 1'b0, 1'b0);
    addCase(K_BNEZ,    16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0);
    addCase(K_JUMP,    16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0);
    addCase(K_ILLEGAL, 16'h0010, 16'h0000, 1'b0, 1'b0, 1'b1);

    for (idx = 0; idx < cases.size(); idx++) begin
      tc = cases[idx];
      a = tc.a;
      b = tc.b;
      if (tc.randA) begin
        rnd = $random(seed);
        a = rnd[15:0];
      end
      if (tc.randB) begin
        rnd = $random(seed);
        b = rnd[15:0];
      end
      runCase(idx, tc.kind, a, b, tc.expErr);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: proc.f
procPkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memStage.sv
unifiedMemory.sv
proc.sv
procTb.sv

// File: Makefile
VERILATOR = verilator
TOP       = procTb
FILELIST  = proc.f
OBJDIR    = obj_dir
SIMFLAGS  = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)
LINTFLAGS = --lint-only --timing -Wall --top-module $(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)
